// File: sim.f
hdl/microrocPkg.sv
hdl/externalRazGenerate.sv
hdl/holdGenerate.sv
hdl/timeStampSyncAndDataTrigger.sv
hdl/chainControlMerge.sv
hdl/microrocCommonControl.sv
dv/clockGen.sv
dv/tbMicrorocCommonControl.sv

// File: dv/tbMicrorocCommonControl.sv
`timescale 1ns/1ps

module tbMicrorocCommonControl;
  import microrocPkg::*;

  localparam int chains      = 4;
  localparam int tsLowCycles = 8; // rstCounterB low time
  localparam int trigExtHigh = 2; // trigExt high time
  localparam int selRaz      = 0;
  localparam int selHold     = 1;
  localparam int selTrig     = 2;
  localparam int selRstCnt   = 3;
  localparam int selAck      = 4;

  logic              Clk, rstN;
  logic              triggerIn, triggerOr, holdEnable;
  logic [7:0]        holdDelay;
  logic [15:0]       holdTime;
  razModeE           razMode;
  logic              externalRazSignalEnable;
  logic [chains-1:0] forceExternalRaz;
  logic [3:0]        externalRazDelayTime;
  logic              slowControlOrReadScopeSelect, resetTimeStampReq;
  logic              dataTrigger, dataTriggerEnable;
  logic [chains-1:0] resetBChain, pwrOnAChain, pwrOnDChain, pwrOnAdcChain, pwrOnDacChain;
  logic [chains-1:0] onceEnd, endReadoutParameter;
  logic              holdSignal, razChn, select, resetB, rstCounterB, resetTimeStampAck;
  logic              trigExt, ramReadoutDone, pwrOnA, pwrOnD, pwrOnAdc, pwrOnDac;

  integer seed = 59;
  int     checks, errors, tests, checkBase, errorBase;

  clockGen clockGen0 (.Clk(Clk), .rstN(rstN));

  microrocCommonControl #(.asicChainNumber(chains)) dut0 (.*);

  ////////////////////////////////////////
  // Model and check helpers
  ////////////////////////////////////////
  function automatic int razWidth(input int mode);
    case (mode)
      0:       return 3;  // 75 ns
      1:       return 10; // 250 ns
      2:       return 20;
      default: return 40; // 1 us
    endcase
  endfunction

  function automatic logic probe(input int sel);
    case (sel)
      selRaz:    return razChn;
      selHold:   return holdSignal;
      selTrig:   return trigExt;
      selRstCnt: return rstCounterB;
      default:   return resetTimeStampAck;
    endcase
  endfunction

  function automatic string sigName(input int sel);
    case (sel)
      selRaz:    return "razChn";
      selHold:   return "holdSignal";
      selTrig:   return "trigExt";
      selRstCnt: return "rstCounterB";
      default:   return "resetTimeStampAck";
    endcase
  endfunction

  task automatic checkEq(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // k counts falling edges since the drive
  task automatic waitLevel(input int sel, input logic level, input int limit,
                           inout int k, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < limit && !ok; n++) begin
      @(negedge Clk);
      k++;
      if (probe(sel) == level) ok = 1'b1;
    end
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: %s did not reach %0b within %0d cycles",
               $time, sigName(sel), level, limit);
    end
  endtask

  task automatic expectQuiet(input int sel, input int cycles);
    int  n;
    bit  seen;
    seen = 1'b0;
    for (n = 0; n < cycles && !seen; n++) begin
      @(negedge Clk);
      if (probe(sel)) seen = 1'b1;
    end
    checks++;
    if (seen) begin
      errors++;
      $display("At %0t %s pulsed although it was disabled", $time, sigName(sel));
    end
  endtask

  task automatic finishTest(input string name);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - checkBase, errors - errorBase);
    checkBase = checks;
    errorBase = errors;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic checkReset();
    int n;
    for (n = 0; n < 10 && rstN !== 1'b1; n++) @(negedge Clk);
    if (rstN !== 1'b1) begin
      errors++;
      $display("Reset was never released");
    end
    checkEq("razChn", razChn, 0);
    checkEq("holdSignal", holdSignal, 0);
    checkEq("trigExt", trigExt, 0);
    checkEq("resetTimeStampAck", resetTimeStampAck, 0);
    checkEq("ramReadoutDone", ramReadoutDone, 0);
    checkEq("pwrOnA", pwrOnA, 0);
    checkEq("pwrOnD", pwrOnD, 0);
    checkEq("pwrOnAdc", pwrOnAdc, 0);
    checkEq("pwrOnDac", pwrOnDac, 0);
    checkEq("rstCounterB", rstCounterB, 1);
    checkEq("select", select, 1);
    checkEq("resetB", resetB, 1);
    finishTest("reset");
  endtask

  task automatic razPulses();
    int i, d, m, k, r;
    bit ok, forced, quiet;
    for (i = 0; i < 20; i++) begin
      d      = {$random(seed)} % 16;
      m      = {$random(seed)} % 4;
      forced = (i % 5 == 4);
      quiet  = (i % 5 == 2); // Enable low so the trigger is ignored
      @(posedge Clk);
      razMode                 <= razModeE'(m);
      externalRazDelayTime    <= 4'(d);
      externalRazSignalEnable <= !quiet;
      @(posedge Clk);
      if (forced) forceExternalRaz <= chains'({$random(seed)} % 15 + 1);
      else        triggerOr        <= 1'b1;
      k = -1;
      if (quiet) begin
        expectQuiet(selRaz, d + 50);
      end else begin
        waitLevel(selRaz, 1'b1, d + 10, k, ok);
        r = k;
        // Sampled at edge 1 and up delay+3 later
        // Force path has no delay
        if (ok) checkEq("razChn rise", k, forced ? 2 : d + 4);
        waitLevel(selRaz, 1'b0, 50, k, ok);
        if (ok) checkEq("razChn width", k - r, razWidth(m));
      end
      @(posedge Clk);
      triggerOr        <= 1'b0;
      forceExternalRaz <= '0;
      repeat (4) @(posedge Clk); // Synchroniser drains
    end
    finishTest("razPulse");
  endtask

  task automatic holdPulses();
    int i, hd, ht, k, r;
    bit ok, quiet;
    for (i = 0; i < 20; i++) begin
      hd    = {$random(seed)} % 51;
      ht    = {$random(seed)} % 60 + 1;
      quiet = (i % 5 == 3);
      @(posedge Clk);
      holdDelay  <= 8'(hd);
      holdTime   <= 16'(ht);
      holdEnable <= !quiet;
      @(posedge Clk);
      triggerIn <= 1'b1;
      k = -1;
      if (quiet) begin
        expectQuiet(selHold, hd + ht + 10);
      end else begin
        waitLevel(selHold, 1'b1, hd + 10, k, ok);
        r = k;
        if (ok) checkEq("holdSignal rise", k, hd + 4);
        waitLevel(selHold, 1'b0, ht + 5, k, ok);
        if (ok) checkEq("holdSignal width", k - r, ht);
      end
      @(posedge Clk);
      triggerIn <= 1'b0;
      repeat (4) @(posedge Clk);
    end
    finishTest("holdPulse");
  endtask

  task automatic timeStampAndTrigger();
    int i, k, f, r;
    bit ok, en;
    for (i = 0; i < 10; i++) begin
      @(posedge Clk);
      resetTimeStampReq <= 1'b1;
      k = -1;
      waitLevel(selRstCnt, 1'b0, 20, k, ok);
      f = k;
      if (ok) checkEq("rstCounterB fall", k, 2);
      waitLevel(selRstCnt, 1'b1, 20, k, ok);
      if (ok) checkEq("rstCounterB low time", k - f, tsLowCycles);
      waitLevel(selAck, 1'b1, 20, k, ok);
      if (ok) checkEq("resetTimeStampAck rise", k, tsLowCycles + 3);
      repeat ({$random(seed)} % 4) @(posedge Clk); // Host response time
      @(posedge Clk);
      resetTimeStampReq <= 1'b0;
      k = -1;
      waitLevel(selAck, 1'b0, 20, k, ok);
      if (ok) checkEq("resetTimeStampAck fall", k, 2);
      repeat (2) @(posedge Clk);
    end
    for (i = 0; i < 10; i++) begin
      en = {$random(seed)} % 2;
      @(posedge Clk);
      dataTriggerEnable <= en;
      dataTrigger       <= 1'b1;
      k = -1;
      if (en) begin
        waitLevel(selTrig, 1'b1, 10, k, ok);
        r = k;
        if (ok) checkEq("trigExt rise", k, 4);
        waitLevel(selTrig, 1'b0, 10, k, ok);
        if (ok) checkEq("trigExt width", k - r, trigExtHigh);
      end else begin
        expectQuiet(selTrig, 10);
      end
      @(posedge Clk);
      dataTrigger <= 1'b0;
      repeat (4) @(posedge Clk);
    end
    finishTest("timeStamp");
  endtask

  task automatic chainMerge();
    int                i, c, k, start, round, doneAt, doneCnt;
    bit                complete;
    logic              scope;
    logic [chains-1:0] rb, pa, pd, padc, pdac, mask, flags;
    for (i = 0; i < 20; i++) begin
      scope = {$random(seed)} % 2;
      rb    = chains'($random(seed));
      pa    = chains'($random(seed));
      pd    = chains'($random(seed));
      padc  = chains'($random(seed));
      pdac  = chains'($random(seed));
      @(posedge Clk);
      slowControlOrReadScopeSelect <= scope;
      resetBChain   <= rb;
      pwrOnAChain   <= pa;
      pwrOnDChain   <= pd;
      pwrOnAdcChain <= padc;
      pwrOnDacChain <= pdac;
      @(negedge Clk);
      @(negedge Clk); // One register stage
      checkEq("select", select, !scope);
      checkEq("resetB", resetB, |rb);
      checkEq("pwrOnA", pwrOnA, |pa);
      checkEq("pwrOnD", pwrOnD, |pd);
      checkEq("pwrOnAdc", pwrOnAdc, |padc);
      checkEq("pwrOnDac", pwrOnDac, |pdac);
    end
    for (round = 0; round < 5; round++) begin
      mask  = chains'({$random(seed)} % 15 + 1);
      flags = '0;
      start = {$random(seed)} % chains;
      @(posedge Clk);
      endReadoutParameter <= mask;
      for (i = 0; i < chains; i++) begin
        c        = (start + i) % chains;
        flags[c] = 1'b1;
        complete = ((flags & mask) == mask); // Every enabled chain has ended
        @(posedge Clk);
        onceEnd <= chains'(1 << c);
        @(posedge Clk);
        onceEnd <= '0;
        doneAt  = -1;
        doneCnt = 0;
        for (k = 1; k <= 6; k++) begin
          @(negedge Clk);
          if (ramReadoutDone) begin
            if (doneAt < 0) doneAt = k;
            doneCnt++;
          end
        end
        checkEq("ramReadoutDone time", doneAt, complete ? 4 : -1);
        checkEq("ramReadoutDone pulses", doneCnt, complete ? 1 : 0);
        if (complete) break;
      end
    end
    finishTest("chainMerge");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    triggerIn                    <= 1'b0;
    triggerOr                    <= 1'b0;
    holdEnable                   <= 1'b0;
    holdDelay                    <= '0;
    holdTime                     <= '0;
    razMode                      <= RAZ75NS;
    externalRazSignalEnable      <= 1'b0;
    forceExternalRaz             <= '0;
    externalRazDelayTime         <= '0;
    slowControlOrReadScopeSelect <= 1'b0;
    resetBChain                  <= '1; // ASICs out of reset
    resetTimeStampReq            <= 1'b0;
    dataTrigger                  <= 1'b0;
    dataTriggerEnable            <= 1'b0;
    pwrOnAChain                  <= '0;
    pwrOnDChain                  <= '0;
    pwrOnAdcChain                <= '0;
    pwrOnDacChain                <= '0;
    onceEnd                      <= '0;
    endReadoutParameter          <= '0;
    checkReset();
    razPulses();
    holdPulses();
    timeStampAndTrigger();
    chainMerge();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
  output logic Clk,
  output logic rstN
);

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk; // 10 ns period, 100 MHz stand-in for Clk
  end

  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge Clk);
    rstN <= 1'b1; // Three cycles in reset
  end

endmodule

// File: hdl/microrocCommonControl.sv
`timescale 1ns/1ps

module microrocCommonControl #(
  parameter int unsigned asicChainNumber = 4
) (
  input  logic                       Clk,
  input  logic                       rstN,
  input  logic                       triggerIn,
  input  logic                       triggerOr,
  // Hold
  input  logic                       holdEnable,
  input  logic [7:0]                 holdDelay,
  input  logic [15:0]                holdTime,
  // External RAZ
  input  microrocPkg::razModeE       razMode,
  input  logic                       externalRazSignalEnable,
  input  logic [asicChainNumber-1:0] forceExternalRaz,
  input  logic [3:0]                 externalRazDelayTime,
  // Per-chain control
  input  logic                       slowControlOrReadScopeSelect,
  input  logic [asicChainNumber-1:0] resetBChain,
  input  logic                       resetTimeStampReq,
  input  logic                       dataTrigger,
  input  logic                       dataTriggerEnable,
  input  logic [asicChainNumber-1:0] pwrOnAChain,
  input  logic [asicChainNumber-1:0] pwrOnDChain,
  input  logic [asicChainNumber-1:0] pwrOnAdcChain,
  input  logic [asicChainNumber-1:0] pwrOnDacChain,
  input  logic [asicChainNumber-1:0] onceEnd,
  input  logic [asicChainNumber-1:0] endReadoutParameter,
  output logic                       holdSignal,
  output logic                       razChn,      // Single-ended, paired on the board
  output logic                       select,
  output logic                       resetB,
  output logic                       rstCounterB,
  output logic                       resetTimeStampAck,
  output logic                       trigExt,
  output logic                       ramReadoutDone,
  output logic                       pwrOnA,
  output logic                       pwrOnD,
  output logic                       pwrOnAdc,
  output logic                       pwrOnDac
);

  ////////////////////////////////////////
  // Parallel controllers
  ////////////////////////////////////////
  externalRazGenerate #(.asicChainNumber(asicChainNumber)) externalRazGen (
    .Clk(Clk), .rstN(rstN),
    .triggerOr   (triggerOr),
    .razEnable   (externalRazSignalEnable),
    .razDelayTime(externalRazDelayTime),
    .razMode     (razMode),
    .forceRaz    (forceExternalRaz),
    .razChn      (razChn)
  );

  holdGenerate holdGen (
    .Clk(Clk), .rstN(rstN),
    .triggerIn(triggerIn), .holdEnable(holdEnable),
    .holdDelay(holdDelay), .holdTime(holdTime),
    .holdSignal(holdSignal)
  );

  timeStampSyncAndDataTrigger timeStampSync (
    .Clk(Clk), .rstN(rstN),
    .resetTimeStampReq(resetTimeStampReq), .dataTrigger(dataTrigger),
    .dataTriggerEnable(dataTriggerEnable), .rstCounterB(rstCounterB),
    .resetTimeStampAck(resetTimeStampAck), .trigExt(trigExt)
  );

  chainControlMerge #(.asicChainNumber(asicChainNumber)) chainMerge (
    .Clk(Clk), .rstN(rstN),
    .slowControlOrReadScopeSelect(slowControlOrReadScopeSelect),
    .resetBChain(resetBChain), .pwrOnAChain(pwrOnAChain), .pwrOnDChain(pwrOnDChain),
    .pwrOnAdcChain(pwrOnAdcChain), .pwrOnDacChain(pwrOnDacChain),
    .onceEnd(onceEnd), .endReadoutParameter(endReadoutParameter),
    .select(select), .resetB(resetB), .pwrOnA(pwrOnA), .pwrOnD(pwrOnD),
    .pwrOnAdc(pwrOnAdc), .pwrOnDac(pwrOnDac), .ramReadoutDone(ramReadoutDone)
  );

endmodule

// File: hdl/chainControlMerge.sv
`timescale 1ns/1ps

module chainControlMerge #(
  parameter int unsigned asicChainNumber = 4
) (
  input  logic                       Clk,
  input  logic                       rstN,
  input  logic                       slowControlOrReadScopeSelect, // 1 slow control, 0 read
  input  logic [asicChainNumber-1:0] resetBChain,
  input  logic [asicChainNumber-1:0] pwrOnAChain,
  input  logic [asicChainNumber-1:0] pwrOnDChain,
  input  logic [asicChainNumber-1:0] pwrOnAdcChain,
  input  logic [asicChainNumber-1:0] pwrOnDacChain,
  input  logic [asicChainNumber-1:0] onceEnd,             // Async, per chain
  input  logic [asicChainNumber-1:0] endReadoutParameter, // Chains that must finish
  output logic                       select,
  output logic                       resetB,
  output logic                       pwrOnA,
  output logic                       pwrOnD,
  output logic                       pwrOnAdc,
  output logic                       pwrOnDac,
  output logic                       ramReadoutDone
);
  import microrocPkg::*;

  logic [asicChainNumber-1:0] endSync [syncStages]; // Stage 0 samples the pins
  logic [asicChainNumber-1:0] endPrev;
  logic [asicChainNumber-1:0] endRise;
  logic [asicChainNumber-1:0] doneFlag; // Chain has finished this readout
  logic                       allDone;

  ////////////////////////////////////////
  // Merged control lines
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      select   <= 1'b1;
      resetB   <= 1'b1; // ASICs out of reset
      pwrOnA   <= 1'b0;
      pwrOnD   <= 1'b0;
      pwrOnAdc <= 1'b0;
      pwrOnDac <= 1'b0;
    end else begin
      select   <= ~slowControlOrReadScopeSelect;
      resetB   <= |resetBChain;
      pwrOnA   <= |pwrOnAChain;   // Power pulsing, any chain on
      pwrOnD   <= |pwrOnDChain;
      pwrOnAdc <= |pwrOnAdcChain;
      pwrOnDac <= |pwrOnDacChain;
    end
  end

  ////////////////////////////////////////
  // Readout done detection
  ////////////////////////////////////////
  assign endRise = endSync[syncStages-1] & ~endPrev;
  // Disabled chains count as done, empty mask never fires
  assign allDone = (|endReadoutParameter) & (&(doneFlag | ~endReadoutParameter));

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < syncStages; i++) endSync[i] <= '0;
      endPrev        <= '0;
      doneFlag       <= '0;
      ramReadoutDone <= 1'b0;
    end else begin
      endSync[0] <= onceEnd;
      for (int i = 1; i < syncStages; i++) endSync[i] <= endSync[i-1];
      endPrev        <= endSync[syncStages-1];
      ramReadoutDone <= allDone;
      // Keep an edge landing on the clearing cycle
      doneFlag       <= allDone ? endRise : (doneFlag | endRise);
    end
  end

endmodule

// File: hdl/timeStampSyncAndDataTrigger.sv
`timescale 1ns/1ps

module timeStampSyncAndDataTrigger (
  input  logic Clk,
  input  logic rstN,
  input  logic resetTimeStampReq, // Host side of the handshake
  input  logic dataTrigger,       // Async
  input  logic dataTriggerEnable,
  output logic rstCounterB,       // Active low counter reset to the ASICs
  output logic resetTimeStampAck,
  output logic trigExt
);
  import microrocPkg::*;

  localparam int unsigned rstCntBits = $clog2(tsResetCycles);
  localparam int unsigned extCntBits = $clog2(trigExtCycles + 1);

  logic                  reqQ;
  tsStateE               tsState;
  logic [rstCntBits-1:0] rstCnt;
  logic [syncStages-1:0] dataSync;
  logic                  dataPrev;
  logic                  dataRise;
  logic                  dataEdgeQ;
  logic [extCntBits-1:0] extCnt;

  ////////////////////////////////////////
  // Time-stamp reset, four-phase
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      reqQ              <= 1'b0;
      tsState           <= TSIDLE;
      rstCnt            <= '0;
      resetTimeStampAck <= 1'b0;
    end else begin
      reqQ <= resetTimeStampReq;
      case (tsState)
        TSIDLE: if (reqQ) begin
          tsState <= TSRESET;
          rstCnt  <= rstCntBits'(tsResetCycles - 1);
        end
        TSRESET: begin
          if (rstCnt == '0) tsState <= TSACK; // Counter reset released
          else              rstCnt  <= rstCnt - 1'b1;
        end
        TSACK: begin
          if (resetTimeStampAck && !reqQ) begin
            resetTimeStampAck <= 1'b0; // Host dropped req
            tsState           <= TSIDLE;
          end else begin
            resetTimeStampAck <= 1'b1;
          end
        end
        default: tsState <= TSIDLE;
      endcase
    end
  end

  assign rstCounterB = (tsState != TSRESET);

  ////////////////////////////////////////
  // External data trigger stretch
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      dataSync  <= '0;
      dataPrev  <= 1'b0;
      dataEdgeQ <= 1'b0;
      extCnt    <= '0;
    end else begin
      dataSync  <= {dataSync[syncStages-2:0], dataTrigger};
      dataPrev  <= dataSync[syncStages-1];
      dataEdgeQ <= dataRise & dataTriggerEnable; // Gate on enable here
      if (dataEdgeQ)           extCnt <= extCntBits'(trigExtCycles);
      else if (extCnt != '0)   extCnt <= extCnt - 1'b1;
    end
  end

  assign dataRise = dataSync[syncStages-1] & ~dataPrev;
  assign trigExt  = (extCnt != '0);

endmodule

// File: hdl/holdGenerate.sv
`timescale 1ns/1ps

module holdGenerate (
  input  logic        Clk,
  input  logic        rstN,
  input  logic        triggerIn,  // Async trigger from the ASICs
  input  logic        holdEnable,
  input  logic [7:0]  holdDelay,  // Cycles between trigger and hold
  input  logic [15:0] holdTime,   // Hold width, 0 means no pulse
  output logic        holdSignal
);
  import microrocPkg::*;

  logic [syncStages-1:0] trigSync;
  logic                  trigPrev;
  logic                  trigRise;
  logic                  trigAccept; // Edge that starts a hold
  pulseStateE            state;
  logic [7:0]            delayCnt;
  logic [15:0]           widthCnt;

  ////////////////////////////////////////
  // Trigger synchroniser
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      trigSync <= '0;
      trigPrev <= 1'b0;
    end else begin
      trigSync <= {trigSync[syncStages-2:0], triggerIn};
      trigPrev <= trigSync[syncStages-1];
    end
  end

  assign trigRise = trigSync[syncStages-1] & ~trigPrev;

  // Zero width would give an empty pulse, so drop it here
  assign trigAccept = trigRise & holdEnable & (holdTime != '0);

  ////////////////////////////////////////
  // Hold FSM
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      state    <= IDLE;
      delayCnt <= '0;
      widthCnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          widthCnt <= holdTime - 1'b1; // Captured on accept
          if (trigAccept) begin
            state    <= DELAY;
            delayCnt <= holdDelay;
          end
        end
        DELAY: begin
          // Triggers in here are ignored
          if (delayCnt == '0) begin
            state <= ACTIVE;
          end else begin
            delayCnt <= delayCnt - 1'b1;
          end
        end
        ACTIVE: begin
          if (widthCnt == '0) begin
            state <= IDLE;
          end else begin
            widthCnt <= widthCnt - 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Straight state decode, one pulse per accepted trigger
  assign holdSignal = (state == ACTIVE);

endmodule

// File: hdl/externalRazGenerate.sv
`timescale 1ns/1ps

module externalRazGenerate #(
  parameter int unsigned asicChainNumber = 4
) (
  input  logic                       Clk,
  input  logic                       rstN,
  input  logic                       triggerOr,    // Async OR of the chain triggers
  input  logic                       razEnable,
  input  logic [3:0]                 razDelayTime, // Extra cycles before the pulse
  input  microrocPkg::razModeE       razMode,
  input  logic [asicChainNumber-1:0] forceRaz,     // One bit per chain
  output logic                       razChn
);
  import microrocPkg::*;

  logic [syncStages-1:0]   trigSync;  // Shift-in synchroniser
  logic                    trigPrev;
  logic                    trigRise;
  logic                    forceQ;    // OR of force bits, sampled
  logic                    forcePrev;
  logic                    forceRise;
  pulseStateE              state;
  logic [3:0]              delayCnt;
  logic [razWidthBits-1:0] widthCnt;

  ////////////////////////////////////////
  // Input sampling and edge detect
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      trigSync  <= '0;
      trigPrev  <= 1'b0;
      forceQ    <= 1'b0;
      forcePrev <= 1'b0;
    end else begin
      trigSync  <= {trigSync[syncStages-2:0], triggerOr};
      trigPrev  <= trigSync[syncStages-1];
      forceQ    <= |forceRaz; // Any chain may force
      forcePrev <= forceQ;
    end
  end

  assign trigRise  = trigSync[syncStages-1] & ~trigPrev;
  assign forceRise = forceQ & ~forcePrev;

  ////////////////////////////////////////
  // Delay and width FSM
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      state    <= IDLE;
      delayCnt <= '0;
      widthCnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          widthCnt <= razWidthCycles[razMode] - 1'b1; // Preload for either path
          if (forceRise) begin
            state <= ACTIVE; // Forced RAZ skips the delay
          end else if (trigRise && razEnable) begin
            state    <= DELAY;
            delayCnt <= razDelayTime;
          end
        end
        DELAY: begin
          if (delayCnt == '0) state <= ACTIVE;
          else                delayCnt <= delayCnt - 1'b1;
        end
        ACTIVE: begin
          if (widthCnt == '0) state <= IDLE; // Last high cycle
          else                widthCnt <= widthCnt - 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign razChn = (state == ACTIVE);

endmodule

// File: hdl/microrocPkg.sv
package microrocPkg;

  ////////////////////////////////////////
  // RAZ pulse width selection
  ////////////////////////////////////////

  // Analogue reset width, picked by the host
  typedef enum logic [1:0] {
    RAZ75NS  = 2'd0, // Shortest, 3 cycles
    RAZ250NS = 2'd1,
    RAZ500NS = 2'd2,
    RAZ1US   = 2'd3  // Longest, 40 cycles
  } razModeE;

  localparam int unsigned razWidthBits = 6; // Holds up to 40

  // Width in Clk cycles at 40 MHz, indexed by razModeE
  localparam logic [razWidthBits-1:0] razWidthCycles [4] = '{3, 10, 20, 40};

  ////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////

  // Delayed pulse generators (RAZ and hold)
  typedef enum logic [1:0] {
    IDLE,   // Waiting for a trigger
    DELAY,  // Counting down the programmed delay
    ACTIVE  // Pulse out
  } pulseStateE;

  // Time-stamp counter reset handshake
  typedef enum logic [1:0] {
    TSIDLE,  // No request pending
    TSRESET, // rstCounterB held low
    TSACK    // Ack up, waiting for req to drop
  } tsStateE;

  localparam int unsigned tsResetCycles = 8; // Low time of rstCounterB
  localparam int unsigned trigExtCycles = 2; // High time of trigExt
  localparam int unsigned syncStages    = 2; // Flops per async input

endpackage
